// ==== run_sim.sh ====
#!/bin/sh
# Builds the rv32i_core testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --timescale 1ns/100ps -f rv32i_core.f \
	--top-module rv32i_core_tb -Mdir "$build_dir"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/Vrv32i_core_tb" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
	echo "Simulation binary exited with status $status"
	exit 1
fi

if grep -q "^Simulation completed successfully$" "$log_file"; then
	exit 0
fi

echo "Pass line not found in $log_file"
exit 1

// ==== rv32i_core.f ====
+incdir+src
+incdir+verification
src/rv32i_types.sv
src/control.sv
src/alu.sv
src/regfile.sv
src/result_select.sv
src/rv32i_core.sv
verification/rv32i_core_tb.sv

// ==== src/alu.sv ====
`timescale 1ns/100ps

module alu import rv32i_types::*; (
	input  rv32i_word      i_pc,
	input  rv32i_word      i_rs1,
	input  rv32i_word      i_rs2,
	input  rv32i_word      i_imm_i,
	input  rv32i_word      i_imm_u,
	input  rv32i_word      i_imm_b,
	input  alumux1_sel_t   i_alumux1_sel,
	input  alumux2_sel_t   i_alumux2_sel,
	input  alu_ops         i_aluop,
	input  cmpmux_sel_t    i_cmpmux_sel,
	input  branch_funct3_t i_cmpop,
	output rv32i_word      o_alu_out,
	output logic           o_br_en
);

	rv32i_word  op1;
	rv32i_word  op2;
	rv32i_word  cmp_b;
	logic [4:0] shamt;

	assign op1 = (i_alumux1_sel == mux1_pc_out) ? i_pc : i_rs1;

	always_comb begin
		case (i_alumux2_sel)
			mux2_u_imm:   op2 = i_imm_u;
			mux2_b_imm:   op2 = i_imm_b;
			mux2_rs2_out: op2 = i_rs2;
			default:      op2 = i_imm_i;
		endcase
	end

	assign shamt = op2[4:0];

	always_comb begin
		case (i_aluop)
			alu_add: o_alu_out = op1 + op2;
			alu_sll: o_alu_out = op1 << shamt;
			alu_sra: o_alu_out = $signed(op1) >>> shamt;
			alu_sub: o_alu_out = op1 - op2;
			alu_xor: o_alu_out = op1 ^ op2;
			alu_srl: o_alu_out = op1 >> shamt;
			alu_or:  o_alu_out = op1 | op2;
			alu_and: o_alu_out = op1 & op2;
			default: o_alu_out = op1 + op2;
		endcase
	end

	// Comparator always has rs1 on the left.
	assign cmp_b = (i_cmpmux_sel == cmpmux_i_imm) ? i_imm_i : i_rs2;

	always_comb begin
		case (i_cmpop)
			beq:     o_br_en = (i_rs1 == cmp_b);
			bne:     o_br_en = (i_rs1 != cmp_b);
			blt:     o_br_en = ($signed(i_rs1) < $signed(cmp_b));
			bge:     o_br_en = ($signed(i_rs1) >= $signed(cmp_b));
			bltu:    o_br_en = (i_rs1 < cmp_b);
			bgeu:    o_br_en = (i_rs1 >= cmp_b);
			default: o_br_en = 1'b0;
		endcase
	end

endmodule

// ==== src/control.sv ====
`timescale 1ns/100ps

module control import rv32i_types::*; (
	input  rv32i_word       i_inst,
	output rv32i_reg        o_src1,
	output rv32i_reg        o_src2,
	output rv32i_reg        o_dest,
	output rv32i_word       o_imm_i,
	output rv32i_word       o_imm_u,
	output rv32i_word       o_imm_b,
	output alumux1_sel_t    o_alumux1_sel,
	output alumux2_sel_t    o_alumux2_sel,
	output alu_ops          o_aluop,
	output cmpmux_sel_t     o_cmpmux_sel,
	output branch_funct3_t  o_cmpop,
	output regfilemux_sel_t o_regfilemux_sel,
	output logic            o_load_regfile,
	output logic            o_is_branch
);

	rv32i_opcode  opcode;
	logic [2:0]   funct3;
	logic [6:0]   funct7;
	logic         is_reg;
	logic         f7_base;
	logic         f7_alt;
	logic         f7_ok;
	alumux2_sel_t op2_sel;
	cmpmux_sel_t  cmp_sel;

	assign opcode = rv32i_opcode'(i_inst[6:0]);
	assign funct3 = i_inst[14:12];
	assign funct7 = i_inst[31:25];

	assign o_src1 = i_inst[19:15];
	assign o_src2 = i_inst[24:20];
	assign o_dest = i_inst[11:7];

	assign o_imm_i = {{21{i_inst[31]}}, i_inst[30:20]};
	assign o_imm_u = {i_inst[31:12], 12'h000};
	assign o_imm_b = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};

	// OP-IMM carries immediate bits where OP carries funct7.
	assign is_reg  = (opcode == op_reg);
	assign f7_base = (funct7 == 7'b0000000);
	assign f7_alt  = (funct7 == 7'b0100000);
	assign f7_ok   = !is_reg || f7_base;

	always_comb begin
		if (is_reg) begin
			op2_sel = mux2_rs2_out;
			cmp_sel = cmpmux_rs2_out;
		end else begin
			op2_sel = mux2_i_imm;
			cmp_sel = cmpmux_i_imm;
		end
	end

	function automatic void set_wb(regfilemux_sel_t sel);
		o_load_regfile = 1'b1;
		o_regfilemux_sel = sel;
	endfunction

	function automatic void set_alu(alumux1_sel_t sel1, alumux2_sel_t sel2, alu_ops op);
		o_alumux1_sel = sel1;
		o_alumux2_sel = sel2;
		o_aluop = op;
	endfunction

	function automatic void set_cmp(cmpmux_sel_t sel, branch_funct3_t op);
		o_cmpmux_sel = sel;
		o_cmpop = op;
	endfunction

	// Register-immediate or register-register arithmetic into rd.
	function automatic void arith(alu_ops op);
		set_wb(rfmux_alu_out);
		set_alu(mux1_rs1_out, op2_sel, op);
	endfunction

	// Set-less-than results come from the comparator.
	function automatic void set_less(branch_funct3_t op);
		set_wb(rfmux_br_en);
		set_cmp(cmp_sel, op);
	endfunction

	always_comb begin
		o_load_regfile = 1'b0;
		o_is_branch = 1'b0;
		o_regfilemux_sel = rfmux_alu_out;
		o_alumux1_sel = mux1_rs1_out;
		o_alumux2_sel = mux2_i_imm;
		o_aluop = alu_add;
		o_cmpmux_sel = cmpmux_rs2_out;
		o_cmpop = beq;
		case (opcode)
			op_lui: begin
				set_wb(rfmux_u_imm);
			end
			op_auipc: begin
				set_wb(rfmux_alu_out);
				set_alu(mux1_pc_out, mux2_u_imm, alu_add);
			end
			op_br: begin
				// ALU forms the target and the comparator decides taken.
				set_alu(mux1_pc_out, mux2_b_imm, alu_add);
				case (branch_funct3_t'(funct3))
					beq, bne, blt, bge, bltu, bgeu: begin
						set_cmp(cmpmux_rs2_out, branch_funct3_t'(funct3));
						o_is_branch = 1'b1;
					end
					default: ;
				endcase
			end
			op_imm, op_reg: begin
				case (arith_funct3_t'(funct3))
					add: begin
						if (is_reg && f7_alt)
							arith(alu_sub);
						else if (f7_ok)
							arith(alu_add);
					end
					sll:  if (f7_base) arith(alu_sll);
					slt:  if (f7_ok) set_less(blt);
					sltu: if (f7_ok) set_less(bltu);
					axor: if (f7_ok) arith(alu_xor);
					sr: begin
						if (f7_base)
							arith(alu_srl);
						else if (f7_alt)
							arith(alu_sra);
					end
					aor:  if (f7_ok) arith(alu_or);
					aand: if (f7_ok) arith(alu_and);
					default: ;
				endcase
			end
			default: ;
		endcase
	end

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/100ps
`include "rv32i_defines.svh"

module regfile import rv32i_types::*; (
	input  logic      clk,
	input  logic      i_rst,
	input  logic      i_wr_en,
	input  rv32i_reg  i_wr_addr,
	input  rv32i_word i_wr_data,
	input  rv32i_reg  i_rd_addr1,
	input  rv32i_reg  i_rd_addr2,
	output rv32i_word o_rd_data1,
	output rv32i_word o_rd_data2
);

	// x0 has no storage.
	rv32i_word regs [1:`RV32I_NUM_REGS-1];

	always_ff @(posedge clk) begin
		if (i_rst) begin
			for (int i = 1; i < `RV32I_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (i_wr_en && (i_wr_addr != '0)) begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	// Write in flight is forwarded so back-to-back users see it.
	always_comb begin
		if (i_rd_addr1 == '0)
			o_rd_data1 = '0;
		else if (i_wr_en && (i_wr_addr == i_rd_addr1))
			o_rd_data1 = i_wr_data;
		else
			o_rd_data1 = regs[i_rd_addr1];
	end

	always_comb begin
		if (i_rd_addr2 == '0)
			o_rd_data2 = '0;
		else if (i_wr_en && (i_wr_addr == i_rd_addr2))
			o_rd_data2 = i_wr_data;
		else
			o_rd_data2 = regs[i_rd_addr2];
	end

endmodule

// ==== src/result_select.sv ====
`timescale 1ns/100ps

module result_select import rv32i_types::*; (
	input  logic            clk,
	input  logic            i_rst,
	input  logic            i_valid,
	input  logic            i_load_regfile,
	input  logic            i_is_branch,
	input  regfilemux_sel_t i_regfilemux_sel,
	input  rv32i_reg        i_dest,
	input  rv32i_word       i_alu_out,
	input  logic            i_br_en,
	input  rv32i_word       i_imm_u,
	input  rv32i_word       i_pc,
	output logic            o_wr_en,
	output rv32i_reg        o_rd,
	output rv32i_word       o_wr_data,
	output logic            o_br_valid,
	output logic            o_br_taken,
	output rv32i_word       o_next_pc
);

	rv32i_word wb_data;
	rv32i_word pc_plus4;

	always_comb begin
		case (i_regfilemux_sel)
			rfmux_br_en: wb_data = rv32i_word'(i_br_en);
			rfmux_u_imm: wb_data = i_imm_u;
			default:     wb_data = i_alu_out;
		endcase
	end

	assign pc_plus4 = i_pc + 32'd4;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_wr_en <= 1'b0;
			o_br_valid <= 1'b0;
			o_br_taken <= 1'b0;
		end else begin
			o_wr_en <= i_valid & i_load_regfile;
			o_br_valid <= i_valid & i_is_branch;
			o_br_taken <= i_valid & i_is_branch & i_br_en;
		end
	end

	// ALU holds pc + B immediate on branches.
	always_ff @(posedge clk) begin
		o_rd <= i_dest;
		o_wr_data <= wb_data;
		o_next_pc <= (i_is_branch && i_br_en) ? i_alu_out : pc_plus4;
	end

endmodule

// ==== src/rv32i_core.sv ====
`timescale 1ns/100ps

module rv32i_core import rv32i_types::*; (
	input  logic      clk,
	input  logic      i_rst,
	input  logic      i_inst_valid,
	input  rv32i_word i_inst,
	input  rv32i_word i_pc,
	output logic      o_wr_en,
	output rv32i_reg  o_rd,
	output rv32i_word o_wr_data,
	output logic      o_br_valid,
	output logic      o_br_taken,
	output rv32i_word o_next_pc
);

	rv32i_reg        src1;
	rv32i_reg        src2;
	rv32i_reg        dest;
	rv32i_word       imm_i;
	rv32i_word       imm_u;
	rv32i_word       imm_b;
	alumux1_sel_t    alumux1_sel;
	alumux2_sel_t    alumux2_sel;
	alu_ops          aluop;
	cmpmux_sel_t     cmpmux_sel;
	branch_funct3_t  cmpop;
	regfilemux_sel_t regfilemux_sel;
	logic            load_regfile;
	logic            is_branch;
	rv32i_word       rs1_out;
	rv32i_word       rs2_out;
	rv32i_word       alu_out;
	logic            br_en;

	control u_control (
		.i_inst           (i_inst),
		.o_src1           (src1),
		.o_src2           (src2),
		.o_dest           (dest),
		.o_imm_i          (imm_i),
		.o_imm_u          (imm_u),
		.o_imm_b          (imm_b),
		.o_alumux1_sel    (alumux1_sel),
		.o_alumux2_sel    (alumux2_sel),
		.o_aluop          (aluop),
		.o_cmpmux_sel     (cmpmux_sel),
		.o_cmpop          (cmpop),
		.o_regfilemux_sel (regfilemux_sel),
		.o_load_regfile   (load_regfile),
		.o_is_branch      (is_branch)
	);

	// Write port is fed from the registered result stage.
	regfile u_regfile (
		.clk        (clk),
		.i_rst      (i_rst),
		.i_wr_en    (o_wr_en),
		.i_wr_addr  (o_rd),
		.i_wr_data  (o_wr_data),
		.i_rd_addr1 (src1),
		.i_rd_addr2 (src2),
		.o_rd_data1 (rs1_out),
		.o_rd_data2 (rs2_out)
	);

	alu u_alu (
		.i_pc          (i_pc),
		.i_rs1         (rs1_out),
		.i_rs2         (rs2_out),
		.i_imm_i       (imm_i),
		.i_imm_u       (imm_u),
		.i_imm_b       (imm_b),
		.i_alumux1_sel (alumux1_sel),
		.i_alumux2_sel (alumux2_sel),
		.i_aluop       (aluop),
		.i_cmpmux_sel  (cmpmux_sel),
		.i_cmpop       (cmpop),
		.o_alu_out     (alu_out),
		.o_br_en       (br_en)
	);

	result_select u_result_select (
		.clk              (clk),
		.i_rst            (i_rst),
		.i_valid          (i_inst_valid),
		.i_load_regfile   (load_regfile),
		.i_is_branch      (is_branch),
		.i_regfilemux_sel (regfilemux_sel),
		.i_dest           (dest),
		.i_alu_out        (alu_out),
		.i_br_en          (br_en),
		.i_imm_u          (imm_u),
		.i_pc             (i_pc),
		.o_wr_en          (o_wr_en),
		.o_rd             (o_rd),
		.o_wr_data        (o_wr_data),
		.o_br_valid       (o_br_valid),
		.o_br_taken       (o_br_taken),
		.o_next_pc        (o_next_pc)
	);

endmodule

// ==== src/rv32i_defines.svh ====
`ifndef RV32I_DEFINES_SVH
`define RV32I_DEFINES_SVH

// Width of a data word, PC and instruction.
`define RV32I_XLEN 32

// Width of a register index.
`define RV32I_REG_ADDR_W 5

// Architectural register count including x0.
`define RV32I_NUM_REGS 32

`endif

// ==== src/rv32i_types.sv ====
`include "rv32i_defines.svh"

package rv32i_types;

	typedef logic [`RV32I_XLEN-1:0] rv32i_word;
	typedef logic [`RV32I_REG_ADDR_W-1:0] rv32i_reg;

	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} rv32i_opcode;

	typedef enum logic [2:0] {
		add  = 3'b000,
		sll  = 3'b001,
		slt  = 3'b010,
		sltu = 3'b011,
		axor = 3'b100,
		sr   = 3'b101,
		aor  = 3'b110,
		aand = 3'b111
	} arith_funct3_t;

	typedef enum logic [2:0] {
		beq  = 3'b000,
		bne  = 3'b001,
		blt  = 3'b100,
		bge  = 3'b101,
		bltu = 3'b110,
		bgeu = 3'b111
	} branch_funct3_t;

	typedef enum logic [2:0] {
		alu_add = 3'b000,
		alu_sll = 3'b001,
		alu_sra = 3'b010,
		alu_sub = 3'b011,
		alu_xor = 3'b100,
		alu_srl = 3'b101,
		alu_or  = 3'b110,
		alu_and = 3'b111
	} alu_ops;

	// Each select literal is prefixed with the name of its mux.
	typedef enum logic {mux1_rs1_out, mux1_pc_out} alumux1_sel_t;

	typedef enum logic [1:0] {mux2_i_imm, mux2_u_imm, mux2_b_imm, mux2_rs2_out} alumux2_sel_t;

	typedef enum logic {cmpmux_rs2_out, cmpmux_i_imm} cmpmux_sel_t;

	typedef enum logic [1:0] {rfmux_alu_out, rfmux_br_en, rfmux_u_imm} regfilemux_sel_t;

endpackage

// ==== verification/rv32i_core_tests.svh ====
`ifndef RV32I_CORE_TESTS_SVH
`define RV32I_CORE_TESTS_SVH

	function automatic rv32i_word op_word(logic [6:0] f7, rv32i_reg rs2, rv32i_reg rs1,
			logic [2:0] f3, rv32i_reg rd);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic rv32i_word imm_word(logic [11:0] imm, rv32i_reg rs1, logic [2:0] f3,
			rv32i_reg rd);
		return {imm, rs1, f3, rd, op_imm};
	endfunction

	function automatic rv32i_word upper_word(logic [19:0] imm, rv32i_reg rd, logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	// Offset bit 0 is implied zero.
	function automatic rv32i_word branch_word(logic [12:0] off, rv32i_reg rs2, rv32i_reg rs1,
			logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_br};
	endfunction

	// RV32I arithmetic by funct3 where alt selects SUB or SRA.
	function automatic rv32i_word arith_result(logic [2:0] f3, logic alt, rv32i_word a,
			rv32i_word b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return 32'($signed(a) < $signed(b));
			3'b011: return 32'(a < b);
			3'b100: return a ^ b;
			3'b101: return alt ? rv32i_word'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(logic [2:0] f3, rv32i_word a, rv32i_word b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic apply_imm(input logic [2:0] f3, input logic [11:0] imm, input rv32i_reg rs1,
			input rv32i_reg rd);
		rv32i_word b;
		logic alt;
		b = {{20{imm[11]}}, imm};
		alt = (f3 == 3'b101) && imm[10];
		write_reg(imm_word(imm, rs1, f3, rd), arith_result(f3, alt, model_regs[rs1], b));
	endtask

	task automatic exec_rr(input logic [2:0] f3, input logic alt, input rv32i_reg rs1,
			input rv32i_reg rs2, input rv32i_reg rd);
		write_reg(op_word(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd),
			arith_result(f3, alt, model_regs[rs1], model_regs[rs2]));
	endtask

	// LUI then ADDI with the upper part rounded for the sign of the low twelve bits.
	task automatic load_value(input rv32i_reg rd, input rv32i_word value);
		logic [19:0] upper;
		upper = value[31:12] + {19'd0, value[11]};
		write_reg(upper_word(upper, rd, op_lui), {upper, 12'h000});
		apply_imm(3'b000, value[11:0], rd, rd);
	endtask

	task automatic load_random(input rv32i_reg rd);
		load_value(rd, $urandom());
	endtask

	task automatic resolve_branch(input logic [2:0] kind, input rv32i_reg rs1,
			input rv32i_reg rs2, input logic [12:0] offset);
		logic taken;
		rv32i_word target;
		taken = branch_taken(kind, model_regs[rs1], model_regs[rs2]);
		target = cur_pc + {{19{offset[12]}}, offset};
		execute(branch_word(offset, rs2, rs1, kind), 1'b0, 32'd0, 1'b1, taken,
			taken ? target : cur_pc + 32'd4);
	endtask

	task automatic no_effect(input rv32i_word inst);
		execute(inst, 1'b0, 32'd0, 1'b0, 1'b0, cur_pc + 32'd4);
	endtask

	// SLTI and SLTIU where signed and unsigned order disagree.
	task automatic slt_pair(input rv32i_word value, input logic [11:0] imm);
		load_value(5'd7, value);
		apply_imm(3'b010, imm, 5'd7, 5'd8);
		apply_imm(3'b011, imm, 5'd7, 5'd9);
	endtask

	task automatic reset_values();
		check("o_wr_en after reset", 32'(o_wr_en), 32'd0);
		check("o_br_valid after reset", 32'(o_br_valid), 32'd0);
		check("o_br_taken after reset", 32'(o_br_taken), 32'd0);
		exec_rr(3'b000, 1'b0, 5'd1, 5'd2, 5'd3);
		check("ADD of cleared registers", o_wr_data, 32'd0);
	endtask

	task automatic upper_immediates();
		rv32i_word rnd;
		rnd = $urandom();
		write_reg(upper_word(rnd[31:12], 5'd4, op_lui), {rnd[31:12], 12'h000});
		rnd = $urandom();
		write_reg(upper_word(rnd[31:12], 5'd5, op_auipc), cur_pc + {rnd[31:12], 12'h000});
		// Sum wraps past zero.
		write_reg(upper_word(20'hFFFFF, 5'd5, op_auipc), cur_pc + 32'hFFFF_F000);
	endtask

	task automatic imm_arith();
		rv32i_word rnd;
		for (int n = 0; n < 3; n++) begin
			load_random(5'd6);
			rnd = $urandom();
			apply_imm(3'b000, rnd[11:0], 5'd6, 5'd8);
			apply_imm(3'b010, rnd[11:0], 5'd6, 5'd9);
			apply_imm(3'b011, rnd[11:0], 5'd6, 5'd10);
			apply_imm(3'b100, rnd[11:0], 5'd6, 5'd8);
			apply_imm(3'b110, rnd[11:0], 5'd6, 5'd9);
			apply_imm(3'b111, rnd[11:0], 5'd6, 5'd10);
			apply_imm(3'b001, {7'h00, rnd[16:12]}, 5'd6, 5'd8);
			apply_imm(3'b101, {7'h00, rnd[16:12]}, 5'd6, 5'd9);
			apply_imm(3'b101, {7'h20, rnd[16:12]}, 5'd6, 5'd10);
		end
		// SRLI and SRAI differ only on a negative value.
		rnd = $urandom();
		load_value(5'd11, rnd | 32'h8000_0000);
		apply_imm(3'b101, {7'h00, 5'd9}, 5'd11, 5'd8);
		apply_imm(3'b101, {7'h20, 5'd9}, 5'd11, 5'd9);
		slt_pair(32'hFFFF_FFFF, 12'h000);
		slt_pair(32'h8000_0000, 12'h7FF);
		slt_pair(32'h0000_0001, 12'hFFF);
		slt_pair(32'h7FFF_FFFF, 12'h800);
	endtask

	task automatic reg_arith_chain();
		rv32i_word rnd;
		for (int n = 0; n < 2; n++) begin
			load_random(5'd12);
			load_random(5'd13);
			// Each step reads the register written by the step just before it.
			exec_rr(3'b000, 1'b0, 5'd12, 5'd13, 5'd14);
			exec_rr(3'b000, 1'b1, 5'd14, 5'd12, 5'd15);
			exec_rr(3'b001, 1'b0, 5'd15, 5'd13, 5'd16);
			exec_rr(3'b010, 1'b0, 5'd16, 5'd12, 5'd17);
			exec_rr(3'b011, 1'b0, 5'd12, 5'd17, 5'd18);
			exec_rr(3'b100, 1'b0, 5'd18, 5'd15, 5'd19);
			exec_rr(3'b101, 1'b0, 5'd19, 5'd13, 5'd20);
			exec_rr(3'b101, 1'b1, 5'd15, 5'd20, 5'd21);
			exec_rr(3'b110, 1'b0, 5'd21, 5'd20, 5'd22);
			exec_rr(3'b111, 1'b0, 5'd22, 5'd22, 5'd22);
			rnd = $urandom();
			load_value(5'd24, rnd | 32'h8000_0000);
			exec_rr(3'b101, 1'b1, 5'd24, 5'd13, 5'd25);
		end
	endtask

	// Register pairs are equal, negative against positive and positive against negative.
	task automatic branch_outcomes();
		branch_funct3_t kinds [0:5];
		rv32i_word rnd;
		logic [12:0] offset;
		kinds = '{beq, bne, blt, bge, bltu, bgeu};
		for (int p = 0; p < 3; p++) begin
			rnd = $urandom();
			if (p == 0) begin
				load_value(5'd26, rnd);
				load_value(5'd27, rnd);
			end else if (p == 1) begin
				load_value(5'd26, rnd | 32'h8000_0000);
				load_value(5'd27, {21'd0, rnd[10:0]});
			end else begin
				load_value(5'd26, {21'd0, rnd[10:0]});
				load_value(5'd27, rnd | 32'h8000_0000);
			end
			for (int k = 0; k < 6; k++) begin
				rnd = $urandom();
				offset = {rnd[12:1], 1'b0};
				resolve_branch(kinds[k], 5'd26, 5'd27, offset);
			end
		end
	endtask

	task automatic dropped_writes();
		apply_imm(3'b000, 12'h123, 5'd26, 5'd0);
		exec_rr(3'b000, 1'b0, 5'd0, 5'd26, 5'd28);
		write_reg(upper_word(20'hABCDE, 5'd0, op_lui), 32'hABCD_E000);
		exec_rr(3'b110, 1'b0, 5'd0, 5'd0, 5'd29);
		// Store, JAL, an unknown opcode and a MUL encoding.
		no_effect({7'h00, 5'd27, 5'd26, 3'b010, 5'd4, op_store});
		no_effect({20'h00100, 5'd1, op_jal});
		no_effect({25'd0, 7'h7F});
		no_effect(op_word(7'h01, 5'd13, 5'd12, 3'b000, 5'd30));
	endtask

`endif

// ==== verification/rv32i_core_tb.sv ====
`timescale 1ns/100ps
`include "rv32i_defines.svh"

module rv32i_core_tb import rv32i_types::*; ();

	localparam int clk_period = 40;
	// Reset plus every test cycle and one closing cycle.
	localparam int run_cycles = 140;
	localparam int watchdog_ns = run_cycles * clk_period * 3 / 2;

	logic      clk;
	logic      i_rst;
	logic      i_inst_valid;
	rv32i_word i_inst;
	rv32i_word i_pc;
	logic      o_wr_en;
	rv32i_reg  o_rd;
	rv32i_word o_wr_data;
	logic      o_br_valid;
	logic      o_br_taken;
	rv32i_word o_next_pc;

	// Expected architectural state.
	rv32i_word model_regs [0:`RV32I_NUM_REGS-1];
	rv32i_word cur_pc;
	int        error_count;
	int        check_count;

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	rv32i_core u_rv32i_core (
		.clk          (clk),
		.i_rst        (i_rst),
		.i_inst_valid (i_inst_valid),
		.i_inst       (i_inst),
		.i_pc         (i_pc),
		.o_wr_en      (o_wr_en),
		.o_rd         (o_rd),
		.o_wr_data    (o_wr_data),
		.o_br_valid   (o_br_valid),
		.o_br_taken   (o_br_taken),
		.o_next_pc    (o_next_pc)
	);

	task automatic check(input string what, input rv32i_word got, input rv32i_word exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Strobe one instruction and check what the result stage shows a cycle later.
	task automatic execute(input rv32i_word inst, input logic exp_wr, input rv32i_word exp_data,
			input logic exp_br, input logic exp_taken, input rv32i_word exp_next);
		rv32i_reg rd;
		rd = inst[11:7];
		i_inst = inst;
		i_pc = cur_pc;
		i_inst_valid = 1'b1;
		@(posedge clk);
		#2;
		i_inst_valid = 1'b0;
		check("o_wr_en", 32'(o_wr_en), 32'(exp_wr));
		check("o_br_valid", 32'(o_br_valid), 32'(exp_br));
		check("o_br_taken", 32'(o_br_taken), 32'(exp_taken));
		check("o_next_pc", o_next_pc, exp_next);
		if (exp_wr) begin
			check("o_rd", 32'(o_rd), 32'(rd));
			check("o_wr_data", o_wr_data, exp_data);
			if (rd != 5'd0)
				model_regs[rd] = exp_data;
		end
		cur_pc = cur_pc + 32'd4;
	endtask

	task automatic write_reg(input rv32i_word inst, input rv32i_word value);
		execute(inst, 1'b1, value, 1'b0, 1'b0, cur_pc + 32'd4);
	endtask

	`include "rv32i_core_tests.svh"

	initial begin
		void'($urandom(32'h0807_b0a7));
		error_count = 0;
		check_count = 0;
		cur_pc = 32'h0000_1000;
		i_rst = 1'b1;
		i_inst_valid = 1'b0;
		i_inst = '0;
		i_pc = '0;
		for (int i = 0; i < `RV32I_NUM_REGS; i++)
			model_regs[i] = '0;
		repeat (10) @(posedge clk);
		#2;
		i_rst = 1'b0;
		reset_values();
		upper_immediates();
		imm_arith();
		reg_arith_chain();
		branch_outcomes();
		dropped_writes();
		@(posedge clk);
		#2;
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("Timeout: tests still running after %0d ns", watchdog_ns);
		$display("Simulation failed");
		$finish;
	end

endmodule
